/* Bender.yml */
package:
  name: open_sort

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/open_sort_pkg.sv
      - rtl/node_store.sv
      - rtl/octile_distance.sv
      - rtl/sort_control.sv
      - rtl/open_sort.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/open_sort_tb.sv

/* open_sort.f */
+incdir+rtl
rtl/open_sort_pkg.sv
rtl/node_store.sv
rtl/octile_distance.sv
rtl/sort_control.sv
rtl/open_sort.sv
sim/open_sort_tb.sv

/* rtl/node_store.sv */
`timescale 1ns/1ps
`include "open_sort_config.svh"

module node_store import open_sort_pkg::*; (
	input  logic   Clk,
	input  logic   Reset,
	input  logic   in_valid,
	input  logic   in_last,
	input  coord_t in_x,
	input  coord_t in_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	output logic   in_ready,
	output logic   out_valid,
	input  logic   out_ready,
	output coord_t out_x,
	output coord_t out_y,
	output logic   out_last,
	output logic   load_done,
	output index_t count,
	input  index_t pair_index,
	input  logic   swap,
	input  logic   sort_done,
	output coord_t entry_a_x,
	output coord_t entry_a_y,
	output coord_t entry_b_x,
	output coord_t entry_b_y,
	output coord_t goal_x_q,
	output coord_t goal_y_q
);

	localparam int ADDR_W = $clog2(`OS_DEPTH);

	coord_t mem_x [0:`OS_DEPTH-1];
	coord_t mem_y [0:`OS_DEPTH-1];

	store_phase_e phase;
	index_t wr_ptr;
	index_t rd_ptr;
	logic [ADDR_W-1:0] wr_addr, rd_addr, addr_a, addr_b;
	logic in_fire, in_end, out_fire;

	assign wr_addr = wr_ptr[ADDR_W-1:0];
	assign rd_addr = rd_ptr[ADDR_W-1:0];
	assign addr_a = pair_index[ADDR_W-1:0];
	assign addr_b = addr_a + 1'b1;

	assign in_ready = (phase == PHASE_LOAD);
	assign in_fire = in_valid && in_ready;
	assign in_end = in_last || (wr_ptr == index_t'(`OS_DEPTH - 1));	// full list ends itself

	assign out_valid = (phase == PHASE_UNLOAD);
	assign out_fire = out_valid && out_ready;
	assign out_x = mem_x[rd_addr];
	assign out_y = mem_y[rd_addr];
	assign out_last = out_valid && (rd_ptr == count - 1'b1);

	// pair seen by the distance units
	assign entry_a_x = mem_x[addr_a];
	assign entry_a_y = mem_y[addr_a];
	assign entry_b_x = mem_x[addr_b];
	assign entry_b_y = mem_y[addr_b];

	//////////////////////////////
	// node array and goal
	always_ff @(posedge Clk)
	begin
		if (in_fire)
		begin
			mem_x[wr_addr] <= in_x;
			mem_y[wr_addr] <= in_y;
			if (wr_ptr == '0)
			begin
				goal_x_q <= goal_x;	// goal rides with the first beat
				goal_y_q <= goal_y;
			end
		end
		if (swap)
		begin
			mem_x[addr_a] <= mem_x[addr_b];
			mem_x[addr_b] <= mem_x[addr_a];
			mem_y[addr_a] <= mem_y[addr_b];
			mem_y[addr_b] <= mem_y[addr_a];
		end
	end

	//////////////////////////////
	// phase and pointers
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			phase <= PHASE_LOAD;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			load_done <= 1'b0;
		end
		else
		begin
			load_done <= 1'b0;
			case (phase)
			PHASE_LOAD:
				if (in_fire)
				begin
					if (in_end)
					begin
						count <= wr_ptr + 1'b1;
						wr_ptr <= '0;
						load_done <= 1'b1;
						phase <= PHASE_SORT;
					end
					else
						wr_ptr <= wr_ptr + 1'b1;
				end
			PHASE_SORT:
				if (sort_done)
				begin
					rd_ptr <= '0;
					phase <= PHASE_UNLOAD;
				end
			PHASE_UNLOAD:
				if (out_fire)
				begin
					if (out_last)
						phase <= PHASE_LOAD;
					else
						rd_ptr <= rd_ptr + 1'b1;	// hold under back-pressure
				end
			default:
				phase <= PHASE_LOAD;
			endcase
		end
	end

	swap_only_in_sort: assert property (@(posedge Clk) disable iff (Reset)
		swap |-> phase == PHASE_SORT);

	// unload starts only from a list being sorted
	done_only_in_sort: assert property (@(posedge Clk) disable iff (Reset)
		sort_done |-> phase == PHASE_SORT);

endmodule

/* rtl/octile_distance.sv */
`timescale 1ns/1ps
`include "open_sort_config.svh"

module octile_distance import open_sort_pkg::*; (
	input  logic   Clk,
	input  logic   Reset,
	input  logic   issue,
	input  coord_t x,
	input  coord_t y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	output cost_t  cost,
	output logic   cost_valid
);

	coord_t dx, dy;
	coord_t hi_q, lo_q;	// longer and shorter leg
	coord_t span;
	logic v1_q;

	assign dx = (x > goal_x) ? x - goal_x : goal_x - x;
	assign dy = (y > goal_y) ? y - goal_y : goal_y - y;
	assign span = hi_q - lo_q;	// straight part of the path

	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			v1_q <= 1'b0;
			cost_valid <= 1'b0;
		end
		else
		begin
			v1_q <= issue;
			cost_valid <= v1_q;
		end
	end

	// cost holds until the next issue
	always_ff @(posedge Clk)
	begin
		if (issue)
		begin
			hi_q <= (dx > dy) ? dx : dy;
			lo_q <= (dx > dy) ? dy : dx;
		end
		if (v1_q)
			cost <= cost_t'(`OS_STRAIGHT_COST) * cost_t'(span)
				+ cost_t'(`OS_DIAG_COST) * cost_t'(lo_q);
	end

endmodule

/* rtl/open_sort.sv */
`timescale 1ns/1ps
`include "open_sort_config.svh"

module open_sort import open_sort_pkg::*; (
	input  logic   Clk,
	input  logic   Reset,
	input  logic   in_valid,
	input  logic   in_last,
	input  coord_t in_x,
	input  coord_t in_y,
	input  coord_t goal_x,
	input  coord_t goal_y,
	output logic   in_ready,
	output logic   out_valid,
	input  logic   out_ready,
	output coord_t out_x,
	output coord_t out_y,
	output logic   out_last
);

	logic load_done, pair_issue, swap, sort_done;
	index_t count, pair_index;
	coord_t entry_a_x, entry_a_y, entry_b_x, entry_b_y;
	coord_t goal_x_q, goal_y_q;
	cost_t cost_a, cost_b;
	logic cost_a_valid;

	node_store store0 (
		.Clk(Clk), .Reset(Reset),
		.in_valid(in_valid), .in_last(in_last), .in_x(in_x), .in_y(in_y),
		.goal_x(goal_x), .goal_y(goal_y), .in_ready(in_ready),
		.out_valid(out_valid), .out_ready(out_ready),
		.out_x(out_x), .out_y(out_y), .out_last(out_last),
		.load_done(load_done), .count(count),
		.pair_index(pair_index), .swap(swap), .sort_done(sort_done),
		.entry_a_x(entry_a_x), .entry_a_y(entry_a_y),
		.entry_b_x(entry_b_x), .entry_b_y(entry_b_y),
		.goal_x_q(goal_x_q), .goal_y_q(goal_y_q)
	);

	// entry i
	octile_distance dist_a (
		.Clk(Clk), .Reset(Reset), .issue(pair_issue),
		.x(entry_a_x), .y(entry_a_y), .goal_x(goal_x_q), .goal_y(goal_y_q),
		.cost(cost_a), .cost_valid(cost_a_valid)
	);

	// entry i+1, its valid matches dist_a
	octile_distance dist_b (
		.Clk(Clk), .Reset(Reset), .issue(pair_issue),
		.x(entry_b_x), .y(entry_b_y), .goal_x(goal_x_q), .goal_y(goal_y_q),
		.cost(cost_b), .cost_valid()
	);

	sort_control ctrl0 (
		.Clk(Clk), .Reset(Reset),
		.load_done(load_done), .count(count),
		.pair_issue(pair_issue), .pair_index(pair_index),
		.cost_a(cost_a), .cost_b(cost_b), .cost_a_valid(cost_a_valid),
		.swap(swap), .sort_done(sort_done)
	);

endmodule

/* rtl/open_sort_config.svh */
`ifndef OPEN_SORT_CONFIG_SVH
`define OPEN_SORT_CONFIG_SVH

// list size and coordinate format
`define OS_DEPTH 16
`define OS_COORD_W 8

// 14 * 255 still fits with room to spare
`define OS_COST_W 12

// octile step weights
`define OS_STRAIGHT_COST 10
`define OS_DIAG_COST 14

`endif

/* rtl/open_sort_pkg.sv */
`include "open_sort_config.svh"

package open_sort_pkg;

	typedef logic [`OS_COORD_W-1:0] coord_t;
	typedef logic [`OS_COST_W-1:0] cost_t;
	typedef logic [$clog2(`OS_DEPTH+1)-1:0] index_t;	// holds OS_DEPTH itself

	typedef enum logic [1:0] {
		PHASE_LOAD,
		PHASE_SORT,
		PHASE_UNLOAD
	} store_phase_e;

	typedef enum logic [2:0] {
		SORT_IDLE,
		SORT_ISSUE,
		SORT_WAIT,
		SORT_COMPARE,
		SORT_PASS_END
	} sort_state_e;

endpackage

/* rtl/sort_control.sv */
`timescale 1ns/1ps
`include "open_sort_config.svh"

module sort_control import open_sort_pkg::*; (
	input  logic   Clk,
	input  logic   Reset,
	input  logic   load_done,
	input  index_t count,
	output logic   pair_issue,
	output index_t pair_index,
	input  cost_t  cost_a,
	input  cost_t  cost_b,
	input  logic   cost_a_valid,
	output logic   swap,
	output logic   sort_done
);

	sort_state_e state;
	logic swapped;	// this pass moved something
	logic a_worse;
	logic last_pair;

	// strict compare keeps equal costs in input order
	assign a_worse = cost_a > cost_b;
	assign last_pair = (pair_index + index_t'(2)) >= count;
	assign swap = (state == SORT_COMPARE) && a_worse;

	//////////////////////////////
	// bubble pass FSM
	always_ff @(posedge Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= SORT_IDLE;
			pair_index <= '0;
			pair_issue <= 1'b0;
			swapped <= 1'b0;
			sort_done <= 1'b0;
		end
		else
		begin
			pair_issue <= 1'b0;
			sort_done <= 1'b0;
			case (state)
			SORT_IDLE:
				if (load_done)
				begin
					pair_index <= '0;
					swapped <= 1'b0;
					if (count < index_t'(2))
						sort_done <= 1'b1;	// nothing to compare
					else
					begin
						pair_issue <= 1'b1;
						state <= SORT_ISSUE;
					end
				end
			SORT_ISSUE:
				state <= SORT_WAIT;
			SORT_WAIT:
				if (cost_a_valid)
					state <= SORT_COMPARE;
			SORT_COMPARE:
			begin
				swapped <= swapped | a_worse;
				if (last_pair)
					state <= SORT_PASS_END;
				else
				begin
					pair_index <= pair_index + 1'b1;
					pair_issue <= 1'b1;
					state <= SORT_ISSUE;
				end
			end
			SORT_PASS_END:
				if (swapped)
				begin
					// another pass from the top
					pair_index <= '0;
					swapped <= 1'b0;
					pair_issue <= 1'b1;
					state <= SORT_ISSUE;
				end
				else
				begin
					sort_done <= 1'b1;
					state <= SORT_IDLE;
				end
			default:
				state <= SORT_IDLE;
			endcase
		end
	end

	// only one pair in flight at a time
	cost_only_in_wait: assert property (@(posedge Clk) disable iff (Reset)
		cost_a_valid |-> state == SORT_WAIT);

	pair_in_list: assert property (@(posedge Clk) disable iff (Reset)
		pair_issue |-> (pair_index + index_t'(1)) < count
			&& count <= index_t'(`OS_DEPTH));

endmodule

/* sim/open_sort_tb.sv */
`timescale 1ns/1ps
`include "open_sort_config.svh"

module open_sort_tb import open_sort_pkg::*; ();

	localparam int TIMEOUT = 5000;	// cycles per wait

	logic Clk, Reset;
	logic in_valid, in_last, in_ready;
	logic out_valid, out_ready, out_last;
	coord_t in_x, in_y, goal_x, goal_y, out_x, out_y;

	logic [15:0] lfsr;
	logic [7:0] ready_bit;
	logic bp_on;	// random out_ready
	int lists_pending;	// lists fully sent but not yet unloaded
	coord_t list_x [0:1][0:`OS_DEPTH-1];
	coord_t list_y [0:1][0:`OS_DEPTH-1];
	coord_t list_gx [0:1];
	coord_t list_gy [0:1];
	int list_n [0:1];
	coord_t exp_x [$];
	coord_t exp_y [$];
	logic exp_last [$];

	open_sort dut0 (.*);

	always #2 Clk = ~Clk;

	//////////////////////////////
	// helpers
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			v = {v[6:0], lfsr[0]};	// one step per bit
		end
	endtask

	function automatic int octile_cost(input int x, input int y, input int gx, input int gy);
		int dx, dy, hi, lo;
		dx = (x > gx) ? x - gx : gx - x;
		dy = (y > gy) ? y - gy : gy - y;
		hi = (dx > dy) ? dx : dy;
		lo = (dx > dy) ? dy : dx;
		return `OS_STRAIGHT_COST * (hi - lo) + `OS_DIAG_COST * lo;
	endfunction

	task automatic make_random(input int s, input int n);
		logic [7:0] v;
		list_n[s] = n;
		for (int i = 0; i < n; i++)
		begin
			take_bits(8, v);
			list_x[s][i] = v;
			take_bits(8, v);
			list_y[s][i] = v;
		end
		take_bits(8, v);
		list_gx[s] = v;
		take_bits(8, v);
		list_gy[s] = v;
	endtask

	// stable insertion sort by octile cost gives the reference order
	task automatic queue_expected(input int s);
		coord_t sx [0:`OS_DEPTH-1];
		coord_t sy [0:`OS_DEPTH-1];
		int c [0:`OS_DEPTH-1];
		coord_t kx, ky;
		int kc, j;
		for (int i = 0; i < list_n[s]; i++)
		begin
			sx[i] = list_x[s][i];
			sy[i] = list_y[s][i];
			c[i] = octile_cost(sx[i], sy[i], list_gx[s], list_gy[s]);
		end
		for (int i = 1; i < list_n[s]; i++)
		begin
			kx = sx[i];
			ky = sy[i];
			kc = c[i];
			j = i - 1;
			while (j >= 0 && c[j] > kc)	// equal costs never pass
			begin
				sx[j+1] = sx[j];
				sy[j+1] = sy[j];
				c[j+1] = c[j];
				j--;
			end
			sx[j+1] = kx;
			sy[j+1] = ky;
			c[j+1] = kc;
		end
		for (int i = 0; i < list_n[s]; i++)
		begin
			exp_x.push_back(sx[i]);
			exp_y.push_back(sy[i]);
			exp_last.push_back(i == list_n[s] - 1);
		end
	endtask

	// called 0.5 ns after a rising edge
	task automatic send_list(input int s, input logic use_last);
		int waited;
		for (int i = 0; i < list_n[s]; i++)
		begin
			in_valid = 1'b1;
			in_x = list_x[s][i];
			in_y = list_y[s][i];
			in_last = use_last && (i == list_n[s] - 1);
			// goal only valid on the first beat
			goal_x = (i == 0) ? list_gx[s] : ~list_gx[s];
			goal_y = (i == 0) ? list_gy[s] : ~list_gy[s];
			waited = 0;
			while (!in_ready)
			begin
				if (waited == TIMEOUT)
					abort_run("input stream never became ready");
				@(posedge Clk);
				#0.5;
				waited++;
			end
			@(posedge Clk);
			#0.5;
		end
		in_valid = 1'b0;
		in_last = 1'b0;
		lists_pending++;
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_x.size() != 0 || lists_pending != 0)
		begin
			if (waited == TIMEOUT)
				abort_run("sorted list did not come out in time");
			@(posedge Clk);
			#0.5;
			waited++;
		end
	endtask

	task automatic run_list(input int s, input logic use_last);
		queue_expected(s);
		send_list(s, use_last);
		wait_drained();
	endtask

	task automatic set_node(input int i, input coord_t x, input coord_t y);
		list_x[0][i] = x;
		list_y[0][i] = y;
	endtask

	//////////////////////////////
	// output side
	always @(posedge Clk)
	begin
		#0.5;
		if (bp_on)
		begin
			take_bits(1, ready_bit);
			out_ready = ready_bit[0];
		end
		else
			out_ready = 1'b1;
	end

	always @(posedge Clk)
	begin : compare_outputs
		logic el;
		#1;
		if (in_valid && in_ready && lists_pending != 0)
			abort_run("input beat accepted while a list was still being sorted or unloaded");
		if (out_valid && out_ready)
		begin
			if (exp_x.size() == 0)
				abort_run("output beat appeared with no node left to expect");
			else
			begin
				el = exp_last.pop_front();
				check_value("out_x", out_x, exp_x.pop_front());
				check_value("out_y", out_y, exp_y.pop_front());
				check_value("out_last", out_last, el);
				if (el)
					lists_pending--;
			end
		end
	end

	//////////////////////////////
	// tests
	initial
	begin
		Clk = 1'b0;
		Reset = 1'b1;
		in_valid = 1'b0;
		in_last = 1'b0;
		in_x = '0;
		in_y = '0;
		goal_x = '0;
		goal_y = '0;
		out_ready = 1'b1;
		bp_on = 1'b0;
		lists_pending = 0;
		lfsr = 16'd37092;
		repeat (8) @(posedge Clk);
		#0.5;
		Reset = 1'b0;

		make_random(0, `OS_DEPTH);	// no in_last so depth ends it
		run_list(0, 1'b0);
		make_random(0, 5);
		run_list(0, 1'b1);
		make_random(0, 1);
		run_list(0, 1'b1);

		// duplicates and ties around (100,100)
		list_n[0] = 8;
		list_gx[0] = 8'd100;
		list_gy[0] = 8'd100;
		set_node(0, 8'd103, 8'd100);
		set_node(1, 8'd100, 8'd97);
		set_node(2, 8'd103, 8'd100);
		set_node(3, 8'd110, 8'd110);
		set_node(4, 8'd97, 8'd103);
		set_node(5, 8'd100, 8'd103);
		set_node(6, 8'd90, 8'd100);
		set_node(7, 8'd103, 8'd103);
		run_list(0, 1'b1);

		make_random(0, 12);
		@(posedge Clk);
		bp_on = 1'b1;
		#0.5;
		run_list(0, 1'b1);
		@(posedge Clk);
		bp_on = 1'b0;
		#0.5;

		// back to back lists with the second goal forced apart
		make_random(0, 7);
		make_random(1, 9);
		list_gx[1] = list_gx[0] + 8'd77;
		queue_expected(0);
		queue_expected(1);
		send_list(0, 1'b1);
		send_list(1, 1'b1);
		wait_drained();

		$display("All tests passed");
		$finish;
	end

endmodule
